//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert --timescale 1ns/1ps
TOP      = axis_weight_rotator_tb
FILELIST = axis_weight_rotator.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = PASS: all tests

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- axis_weight_rotator.f
+incdir+design
design/rotator_ctrl_pkg.sv
design/rotator_stream_pkg.sv
design/weight_bank_ram.sv
design/rotator_counters.sv
design/rotator_fsm.sv
design/rotator_out_buffer.sv
design/axis_weight_rotator.sv
verif/rotator_assertions.sv
verif/rotator_checker.sv
verif/axis_weight_rotator_tb.sv

//--- design/axis_weight_rotator.sv
`default_nettype none

`include "rotator_config.svh"

module axis_weight_rotator
  import rotator_stream_pkg::*;
(
  input  logic                   aclk,
  input  logic                   rst,
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  input  logic [`ROT_DATA_W-1:0] s_axis_tdata,
  // packet length comes from the configuration beat, tlast is not checked
  input  logic                   s_axis_tlast,
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  output logic [`ROT_DATA_W-1:0] m_axis_tdata,
  output logic [TUSER_W-1:0]     m_axis_tuser,
  output logic                   m_axis_tlast
);

  logic                   cfg_load;
  logic [`ROT_KH_W-1:0]   cfg_kh_1;
  logic [`ROT_CIN_W-1:0]  cfg_cin_1;
  logic [`ROT_REP_W-1:0]  cfg_rep_1;
  logic                   wr_en;
  logic                   wr_bank;
  logic                   rd_en;
  logic                   rd_bank;
  logic                   pass_start;
  logic                   rd_first;
  logic                   rd_last_pass;
  logic [`ROT_ADDR_W-1:0] wr_addr;
  logic [`ROT_ADDR_W-1:0] rd_addr;
  logic                   wr_done;
  logic                   rd_pass_end;
  logic                   rd_all_end;
  logic                   space;
  logic [`ROT_DATA_W-1:0] rd_data;
  logic                   rd_vld_q;
  logic [TUSER_W-1:0]     rd_user_q;
  logic                   rd_last_q;

  rotator_fsm u_fsm (
    .aclk          (aclk),
    .rst           (rst),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tdata  (s_axis_tdata),
    .wr_done       (wr_done),
    .rd_pass_end   (rd_pass_end),
    .rd_all_end    (rd_all_end),
    .space         (space),
    .s_axis_tready (s_axis_tready),
    .cfg_load      (cfg_load),
    .cfg_kh_1      (cfg_kh_1),
    .cfg_cin_1     (cfg_cin_1),
    .cfg_rep_1     (cfg_rep_1),
    .wr_en         (wr_en),
    .wr_bank       (wr_bank),
    .rd_en         (rd_en),
    .rd_bank       (rd_bank),
    .pass_start    (pass_start),
    .rd_first      (rd_first),
    .rd_last_pass  (rd_last_pass)
  );

  rotator_counters u_counters (
    .aclk        (aclk),
    .rst         (rst),
    .cfg_load    (cfg_load),
    .cfg_kh_1    (cfg_kh_1),
    .cfg_cin_1   (cfg_cin_1),
    .cfg_rep_1   (cfg_rep_1),
    .wr_en       (wr_en),
    .rd_en       (rd_en),
    .pass_start  (pass_start),
    .wr_addr     (wr_addr),
    .rd_addr     (rd_addr),
    .wr_done     (wr_done),
    .rd_pass_end (rd_pass_end),
    .rd_all_end  (rd_all_end)
  );

  weight_bank_ram u_ram (
    .aclk    (aclk),
    .wr_en   (wr_en),
    .wr_bank (wr_bank),
    .wr_addr (wr_addr),
    .wr_data (s_axis_tdata),
    .rd_en   (rd_en),
    .rd_bank (rd_bank),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // tags wait one cycle so they line up with rd_data
  always_ff @(posedge aclk) begin
    if (rst) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_en;
    end
  end

  always_ff @(posedge aclk) begin
    rd_user_q[TU_PASS_FIRST] <= rd_first;
    rd_user_q[TU_PASS_LAST]  <= rd_last_pass;
    rd_last_q                <= rd_all_end;
  end

  rotator_out_buffer u_out_buffer (
    .aclk          (aclk),
    .rst           (rst),
    .in_valid      (rd_vld_q),
    .in_data       (rd_data),
    .in_user       (rd_user_q),
    .in_last       (rd_last_q),
    .space         (space),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

`default_nettype wire

//--- design/rotator_config.svh
`ifndef ROTATOR_CONFIG_SVH
`define ROTATOR_CONFIG_SVH

// stream beat width, same on both sides
`define ROT_DATA_W 32

// weight beats held by one bank
`define ROT_BANK_DEPTH 64

// bank address width, log2 of the depth
`define ROT_ADDR_W 6

// configuration beat fields, each stored as value minus one
`define ROT_KH_W 2
`define ROT_CIN_W 4
`define ROT_REP_W 4

`endif

//--- design/rotator_counters.sv
`default_nettype none

`include "rotator_config.svh"

module rotator_counters (
  input  logic                   aclk,
  input  logic                   rst,
  input  logic                   cfg_load,
  input  logic [`ROT_KH_W-1:0]   cfg_kh_1,
  input  logic [`ROT_CIN_W-1:0]  cfg_cin_1,
  input  logic [`ROT_REP_W-1:0]  cfg_rep_1,
  input  logic                   wr_en,
  input  logic                   rd_en,
  input  logic                   pass_start,
  output logic [`ROT_ADDR_W-1:0] wr_addr,
  output logic [`ROT_ADDR_W-1:0] rd_addr,
  output logic                   wr_done,
  output logic                   rd_pass_end,
  output logic                   rd_all_end
);

  localparam int ADDR_W = `ROT_ADDR_W;
  localparam int REP_W  = `ROT_REP_W;

  logic [ADDR_W-1:0] kh_n;
  logic [ADDR_W-1:0] cin_n;
  logic [ADDR_W-1:0] cfg_last;
  logic [ADDR_W-1:0] beats_last [2];
  logic [REP_W-1:0]  reps_last [2];
  logic [REP_W-1:0]  pass;
  logic              load_slot;
  logic              read_slot;

  // a full 64 beat product wraps to zero, minus one gives 63
  assign kh_n     = ADDR_W'(cfg_kh_1) + ADDR_W'(1);
  assign cin_n    = ADDR_W'(cfg_cin_1) + ADDR_W'(1);
  assign cfg_last = kh_n * cin_n - ADDR_W'(1);

  // slots follow the banks, both sides step through them in order
  always_ff @(posedge aclk) begin
    if (cfg_load) begin
      beats_last[load_slot] <= cfg_last;
      reps_last[load_slot]  <= cfg_rep_1;
    end
  end

  assign wr_done     = wr_addr == beats_last[load_slot];
  assign rd_pass_end = rd_addr == beats_last[read_slot];
  assign rd_all_end  = rd_pass_end && (pass == reps_last[read_slot]);

  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_addr   <= '0;
      load_slot <= 1'b0;
    end else if (wr_en) begin
      if (wr_done) begin
        wr_addr   <= '0;
        load_slot <= ~load_slot;
      end else begin
        wr_addr <= wr_addr + ADDR_W'(1);
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      rd_addr   <= '0;
      pass      <= '0;
      read_slot <= 1'b0;
    end else if (pass_start) begin
      rd_addr <= '0;
      pass    <= '0;
    end else if (rd_en) begin
      if (rd_pass_end) begin
        rd_addr <= '0;
        if (rd_all_end) begin
          pass      <= '0;
          read_slot <= ~read_slot;
        end else begin
          pass <= pass + REP_W'(1);
        end
      end else begin
        rd_addr <= rd_addr + ADDR_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- design/rotator_ctrl_pkg.sv
`default_nettype none

package rotator_ctrl_pkg;

  // load side position within a packet
  typedef enum logic [1:0] {
    L_CONFIG,
    L_WEIGHTS,
    L_WAIT_BANK
  } load_state_t;

  // replay side, drain means waiting for room in the output buffer
  typedef enum logic [1:0] {
    R_IDLE,
    R_READ,
    R_DRAIN
  } replay_state_t;

endpackage

`default_nettype wire

//--- design/rotator_fsm.sv
`default_nettype none

`include "rotator_config.svh"

module rotator_fsm
  import rotator_ctrl_pkg::*;
  import rotator_stream_pkg::*;
(
  input  logic                  aclk,
  input  logic                  rst,
  input  logic                  s_axis_tvalid,
  input  logic [`ROT_DATA_W-1:0] s_axis_tdata,
  input  logic                  wr_done,
  input  logic                  rd_pass_end,
  input  logic                  rd_all_end,
  input  logic                  space,
  output logic                  s_axis_tready,
  output logic                  cfg_load,
  output logic [`ROT_KH_W-1:0]  cfg_kh_1,
  output logic [`ROT_CIN_W-1:0] cfg_cin_1,
  output logic [`ROT_REP_W-1:0] cfg_rep_1,
  output logic                  wr_en,
  output logic                  wr_bank,
  output logic                  rd_en,
  output logic                  rd_bank,
  output logic                  pass_start,
  output logic                  rd_first,
  output logic                  rd_last_pass
);

  load_state_t   ld_state;
  replay_state_t rp_state;
  cfg_fields_t   cfg;
  logic [1:0]    bank_full;
  logic          wr_fill;
  logic          rd_free;
  logic          first_pend;

  assign cfg       = cfg_fields_t'(s_axis_tdata[$bits(cfg_fields_t)-1:0]);
  assign cfg_kh_1  = cfg.kh_1;
  assign cfg_cin_1 = cfg.cin_1;
  assign cfg_rep_1 = cfg.rep_1;

  assign s_axis_tready = ld_state != L_WAIT_BANK;
  assign cfg_load      = (ld_state == L_CONFIG) && s_axis_tvalid;
  assign wr_en         = (ld_state == L_WEIGHTS) && s_axis_tvalid;
  assign wr_fill       = wr_en && wr_done;

  // reads only go out while the buffer has room for them
  assign rd_en        = (rp_state == R_READ) && space;
  assign rd_free      = rd_en && rd_all_end;
  assign pass_start   = (rp_state == R_IDLE) && bank_full[rd_bank];
  assign rd_first     = rd_en && first_pend;
  assign rd_last_pass = rd_en && rd_pass_end;

  always_ff @(posedge aclk) begin
    if (rst) begin
      ld_state <= L_CONFIG;
      wr_bank  <= 1'b0;
    end else begin
      case (ld_state)
        L_CONFIG: begin
          if (cfg_load) ld_state <= L_WEIGHTS;
        end
        L_WEIGHTS: begin
          if (wr_fill) begin
            wr_bank  <= ~wr_bank;
            ld_state <= bank_full[~wr_bank] ? L_WAIT_BANK : L_CONFIG;
          end
        end
        L_WAIT_BANK: begin
          if (!bank_full[wr_bank]) ld_state <= L_CONFIG;
        end
        default: ld_state <= L_CONFIG;
      endcase
    end
  end

  // full bits hand each bank from the load side to the replay side and back
  always_ff @(posedge aclk) begin
    if (rst) begin
      bank_full <= 2'b00;
    end else begin
      if (wr_fill) bank_full[wr_bank] <= 1'b1;
      if (rd_free) bank_full[rd_bank] <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      rp_state   <= R_IDLE;
      rd_bank    <= 1'b0;
      first_pend <= 1'b0;
    end else begin
      case (rp_state)
        R_IDLE: begin
          if (pass_start) rp_state <= R_READ;
        end
        R_READ: begin
          if (rd_free) begin
            rp_state <= R_IDLE;
            rd_bank  <= ~rd_bank;
          end else if (!space) begin
            rp_state <= R_DRAIN;
          end
        end
        R_DRAIN: begin
          if (space) rp_state <= R_READ;
        end
        default: rp_state <= R_IDLE;
      endcase
      // next read after a pass boundary opens a new pass
      if (pass_start || (rd_en && rd_pass_end)) begin
        first_pend <= 1'b1;
      end else if (rd_en) begin
        first_pend <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/rotator_out_buffer.sv
`default_nettype none

`include "rotator_config.svh"

module rotator_out_buffer
  import rotator_stream_pkg::*;
(
  input  logic                   aclk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  logic [`ROT_DATA_W-1:0] in_data,
  input  logic [TUSER_W-1:0]     in_user,
  input  logic                   in_last,
  output logic                   space,
  input  logic                   m_axis_tready,
  output logic                   m_axis_tvalid,
  output logic [`ROT_DATA_W-1:0] m_axis_tdata,
  output logic [TUSER_W-1:0]     m_axis_tuser,
  output logic                   m_axis_tlast
);

  localparam int DATA_W = `ROT_DATA_W;

  logic [DATA_W-1:0]  data_q [2];
  logic [TUSER_W-1:0] user_q [2];
  logic               last_q [2];
  logic               wr_ptr;
  logic               rd_ptr;
  logic [1:0]         count;
  logic [1:0]         occ;
  logic               pop;

  assign pop = m_axis_tvalid && m_axis_tready;

  // occupancy next cycle, counting the result already coming out of the RAM
  assign occ   = count + {1'b0, in_valid} - {1'b0, pop};
  // room for the read in flight and one more
  assign space = occ < 2'd2;

  assign m_axis_tvalid = count != 2'd0;
  assign m_axis_tdata  = data_q[rd_ptr];
  assign m_axis_tuser  = user_q[rd_ptr];
  assign m_axis_tlast  = last_q[rd_ptr];

  always_ff @(posedge aclk) begin
    if (in_valid) begin
      data_q[wr_ptr] <= in_data;
      user_q[wr_ptr] <= in_user;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      count     <= 2'd0;
      last_q[0] <= 1'b0;
      last_q[1] <= 1'b0;
    end else begin
      // an empty entry never carries a last flag
      if (pop) last_q[rd_ptr] <= 1'b0;
      if (in_valid) last_q[wr_ptr] <= in_last;
      if (in_valid) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      count <= occ;
    end
  end

endmodule

`default_nettype wire

//--- design/rotator_stream_pkg.sv
`default_nettype none

`include "rotator_config.svh"

package rotator_stream_pkg;

  localparam int TUSER_W = 2;

  // bit positions within m_axis_tuser
  typedef enum logic {
    TU_PASS_FIRST = 1'b0,
    TU_PASS_LAST  = 1'b1
  } tuser_bit_e;

  // low bits of the configuration beat, kh_1 sits at bit 0
  typedef struct packed {
    logic [`ROT_REP_W-1:0] rep_1;
    logic [`ROT_CIN_W-1:0] cin_1;
    logic [`ROT_KH_W-1:0]  kh_1;
  } cfg_fields_t;

endpackage

`default_nettype wire

//--- design/weight_bank_ram.sv
`default_nettype none

`include "rotator_config.svh"

module weight_bank_ram (
  input  logic                   aclk,
  input  logic                   wr_en,
  input  logic                   wr_bank,
  input  logic [`ROT_ADDR_W-1:0] wr_addr,
  input  logic [`ROT_DATA_W-1:0] wr_data,
  input  logic                   rd_en,
  input  logic                   rd_bank,
  input  logic [`ROT_ADDR_W-1:0] rd_addr,
  output logic [`ROT_DATA_W-1:0] rd_data
);

  localparam int DATA_W = `ROT_DATA_W;
  localparam int DEPTH  = `ROT_BANK_DEPTH;

  // both banks in one array, bank select is the top address bit
  logic [DATA_W-1:0] mem [2*DEPTH];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[{wr_bank, wr_addr}] <= wr_data;
    end
  end

  // registered read, data is valid the cycle after rd_en
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= mem[{rd_bank, rd_addr}];
    end
  end

endmodule

`default_nettype wire

//--- verif/axis_weight_rotator_tb.sv
`default_nettype none

`include "rotator_config.svh"

module axis_weight_rotator_tb
  import rotator_stream_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS = 8;
  localparam logic [31:0] SEED = 32'h0ef14294;

  typedef struct packed {
    logic [`ROT_KH_W-1:0]  kh_1;
    logic [`ROT_CIN_W-1:0] cin_1;
    logic [`ROT_REP_W-1:0] rep_1;
    logic                  bp;
  } row_t;

  // packets go out back to back, so neighbouring rows overlap in the DUT
  string names [NUM_TESTS] = '{"replay_3x3", "pingpong_a", "pingpong_b", "backpressure",
                               "min_packet", "max_packet", "after_max_a", "after_max_b"};
  row_t  rows [NUM_TESTS] = '{
    '{2'd2, 4'd2,  4'd3,  1'b0},
    '{2'd1, 4'd3,  4'd2,  1'b0},
    '{2'd3, 4'd1,  4'd1,  1'b0},
    '{2'd3, 4'd4,  4'd2,  1'b1},
    '{2'd0, 4'd0,  4'd0,  1'b0},
    '{2'd3, 4'd15, 4'd15, 1'b0},
    '{2'd2, 4'd3,  4'd1,  1'b1},
    '{2'd1, 4'd2,  4'd0,  1'b0}
  };

  logic                   aclk;
  logic                   rst;
  logic                   s_axis_tvalid;
  logic                   s_axis_tready;
  logic [`ROT_DATA_W-1:0] s_axis_tdata;
  logic                   s_axis_tlast;
  logic                   m_axis_tvalid;
  logic                   m_axis_tready = 1'b0;
  logic [`ROT_DATA_W-1:0] m_axis_tdata;
  logic [TUSER_W-1:0]     m_axis_tuser;
  logic                   m_axis_tlast;
  int                     tests_done;
  int                     tests_failed;
  int                     err_count;
  int                     out_test;

  axis_weight_rotator DUT (.*);

  rotator_checker u_checker (.*);

  function automatic int beats_of(input row_t r);
    return (int'(r.kh_1) + 1) * (int'(r.cin_1) + 1);
  endfunction

  task automatic send_beat(input logic [`ROT_DATA_W-1:0] data, input logic last);
    s_axis_tvalid <= 1'b1;
    s_axis_tdata  <= data;
    s_axis_tlast  <= last;
    @(posedge aclk);
    while (!s_axis_tready) @(posedge aclk);
  endtask

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // the row whose beats are coming out decides the back-pressure
  always @(posedge aclk) begin
    logic [31:0] coin;
    coin = $urandom;
    if (rst) m_axis_tready <= 1'b0;
    else if (out_test < NUM_TESTS && rows[out_test].bp) m_axis_tready <= coin[0];
    else m_axis_tready <= 1'b1;
  end

  initial begin
    int limit;
    limit = 200;
    for (int t = 0; t < NUM_TESTS; t++) begin
      limit += 4 * beats_of(rows[t]) * (int'(rows[t].rep_1) + 1);
    end
    repeat (limit) @(posedge aclk);
    $display("Timeout: run stopped after %0d cycles, %0d of %0d tests finished",
             limit, tests_done, NUM_TESTS);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int                     n;
    int                     missing;
    int                     asrt;
    logic [TUSER_W-1:0]     user;
    logic [`ROT_DATA_W-1:0] weights [`ROT_BANK_DEPTH];
    void'($urandom(SEED));
    rst           = 1'b1;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tlast  = 1'b0;
    repeat (3) @(posedge aclk);
    rst <= 1'b0;
    // idle cycles, m_axis_tvalid has to stay low
    repeat (5) @(posedge aclk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      n = beats_of(rows[t]);
      for (int b = 0; b < n; b++) weights[b] = $urandom;
      u_checker.expect_test(names[t], n);
      for (int p = 0; p <= int'(rows[t].rep_1); p++) begin
        for (int b = 0; b < n; b++) begin
          user = '0;
          user[TU_PASS_FIRST] = (b == 0);
          user[TU_PASS_LAST]  = (b == n - 1);
          u_checker.expect_beat(weights[b], user, (p == int'(rows[t].rep_1)) && (b == n - 1));
        end
      end
      send_beat({22'd0, rows[t].rep_1, rows[t].cin_1, rows[t].kh_1}, 1'b0);
      for (int b = 0; b < n; b++) send_beat(weights[b], b == n - 1);
    end
    s_axis_tvalid <= 1'b0;
    s_axis_tlast  <= 1'b0;
    wait (tests_done == NUM_TESTS);
    @(posedge aclk);
    missing = u_checker.count_missing_events();
    asrt    = DUT.u_assertions.failures;
    $display("tests %0d, failed %0d, errors %0d, missing events %0d, assertion failures %0d",
             tests_done, tests_failed, err_count, missing, asrt);
    if (err_count == 0 && tests_failed == 0 && missing == 0 && asrt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/rotator_assertions.sv
`default_nettype none

`include "rotator_config.svh"

module rotator_assertions
  import rotator_stream_pkg::*;
(
  input logic                   aclk,
  input logic                   rst,
  input logic                   s_axis_tvalid,
  input logic                   s_axis_tready,
  input logic [`ROT_DATA_W-1:0] s_axis_tdata,
  input logic                   m_axis_tvalid,
  input logic                   m_axis_tready,
  input logic [`ROT_DATA_W-1:0] m_axis_tdata,
  input logic [TUSER_W-1:0]     m_axis_tuser,
  input logic                   m_axis_tlast
);

  timeunit 1ns;
  timeprecision 1ps;

  int slave_fails = 0;
  int master_fails = 0;
  int reset_fails = 0;
  int tlast_fails = 0;
  int failures;

  assign failures = slave_fails + master_fails + reset_fails + tlast_fails;

  // a waiting beat keeps valid and data until it moves
  slave_hold: assert property (@(posedge aclk) disable iff (rst)
    s_axis_tvalid && !s_axis_tready |=> s_axis_tvalid && $stable(s_axis_tdata))
    else begin
      $error("slave beat changed while s_axis_tready was low");
      slave_fails++;
    end

  master_hold: assert property (@(posedge aclk) disable iff (rst)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
      && $stable(m_axis_tuser) && $stable(m_axis_tlast))
    else begin
      $error("master beat changed while m_axis_tready was low");
      master_fails++;
    end

  reset_idle: assert property (@(posedge aclk) rst |=> !m_axis_tvalid)
    else begin
      $error("m_axis_tvalid high after reset");
      reset_fails++;
    end

  tlast_valid: assert property (@(posedge aclk) m_axis_tlast |-> m_axis_tvalid)
    else begin
      $error("m_axis_tlast high without m_axis_tvalid");
      tlast_fails++;
    end

endmodule

bind axis_weight_rotator rotator_assertions u_assertions (
  .aclk          (aclk),
  .rst           (rst),
  .s_axis_tvalid (s_axis_tvalid),
  .s_axis_tready (s_axis_tready),
  .s_axis_tdata  (s_axis_tdata),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tuser  (m_axis_tuser),
  .m_axis_tlast  (m_axis_tlast)
);

`default_nettype wire

//--- verif/rotator_checker.sv
`default_nettype none

`include "rotator_config.svh"

module rotator_checker
  import rotator_stream_pkg::*;
(
  input  logic                   aclk,
  input  logic                   rst,
  input  logic                   s_axis_tvalid,
  input  logic                   s_axis_tready,
  input  logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  input  logic [`ROT_DATA_W-1:0] m_axis_tdata,
  input  logic [TUSER_W-1:0]     m_axis_tuser,
  input  logic                   m_axis_tlast,
  output int                     tests_done,
  output int                     tests_failed,
  output int                     err_count,
  output int                     out_test
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [`ROT_DATA_W-1:0] exp_data_q [$];
  logic [TUSER_W-1:0]     exp_user_q [$];
  logic                   exp_last_q [$];
  string                  name_q [$];
  int                     len_q [$];
  int                     beat_in_test = 0;
  int                     test_errs = 0;
  int                     first_len = -1;
  int                     slave_beats = 0;
  logic                   overlap_seen = 1'b0;
  logic                   stall_seen = 1'b0;
  logic                   early_seen = 1'b0;

  // first packet length counts the configuration beat too
  task automatic expect_test(input string name, input int beats);
    if (first_len < 0) begin
      first_len = beats + 1;
    end
    name_q.push_back(name);
    len_q.push_back(beats);
  endtask

  task automatic expect_beat(input logic [`ROT_DATA_W-1:0] data,
                             input logic [TUSER_W-1:0] user, input logic last);
    exp_data_q.push_back(data);
    exp_user_q.push_back(user);
    exp_last_q.push_back(last);
  endtask

  function automatic int count_missing_events();
    int missing;
    missing = 0;
    if (!overlap_seen) begin
      $display("No packet was loaded while another packet was replaying");
      missing++;
    end
    if (!stall_seen) begin
      $display("s_axis_tready never held back a packet during a full bank replay");
      missing++;
    end
    return missing;
  endfunction

  always @(posedge aclk) begin
    logic [`ROT_DATA_W-1:0] ed;
    logic [TUSER_W-1:0]     eu;
    logic                   el;
    string                  cur_name;
    if (!rst) begin
      if (!early_seen && m_axis_tvalid && (first_len < 0 || slave_beats < first_len)) begin
        early_seen = 1'b1;
        $display("m_axis_tvalid rose before the first packet was stored");
        err_count++;
      end
      if (s_axis_tvalid && s_axis_tready) begin
        if (m_axis_tvalid) overlap_seen = 1'b1;
        slave_beats++;
      end
      // a waiting packet while a full bank is coming out
      if (s_axis_tvalid && !s_axis_tready && len_q.size() > 0
          && len_q[0] == `ROT_BANK_DEPTH) begin
        stall_seen = 1'b1;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        if (exp_data_q.size() == 0) begin
          $display("Output beat %h arrived with no beat expected", m_axis_tdata);
          err_count++;
        end else begin
          ed = exp_data_q.pop_front();
          eu = exp_user_q.pop_front();
          el = exp_last_q.pop_front();
          if ({ed, eu, el} !== {m_axis_tdata, m_axis_tuser, m_axis_tlast}) begin
            // data, tuser and tlast in that order
            $display("Mismatch in %s beat %0d: expected %h %b %b, actual %h %b %b",
                     name_q[0], beat_in_test, ed, eu, el, m_axis_tdata, m_axis_tuser,
                     m_axis_tlast);
            err_count++;
            test_errs++;
          end
          beat_in_test++;
          // the expected tlast closes a test even when the DUT misses it
          if (el) begin
            cur_name = name_q.pop_front();
            void'(len_q.pop_front());
            if (test_errs == 0) begin
              $display("test %s: ok, %0d beats", cur_name, beat_in_test);
            end else begin
              $display("test %s: %0d errors in %0d beats", cur_name, test_errs, beat_in_test);
              tests_failed++;
            end
            tests_done++;
            out_test <= out_test + 1;
            beat_in_test = 0;
            test_errs = 0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire
